// ==== Makefile ====
TOP := tb_i2c_master

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f sources.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== include/i2c_cfg.svh ====
// half period must be even and at least 4 cycles; page size is tied to the 32-bit data word
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// clk cycles per scl half period
// 12 gives scl = clk / 24
`define I2C_HALF_CYCLES 12

// divider counter width, must hold I2C_HALF_CYCLES - 1
`define I2C_CNT_W 5

// bytes moved by a page write or a sequential read
`define I2C_PAGE_BYTES 4

`endif

// ==== sim/eeprom_model.sv ====
// single 7-bit address, no write delay; the pointer wraps at 256; memory starts address filled
`timescale 1ns/10ps

module eeprom_model import i2c_pkg::*; #(
	parameter logic [6:0] DEV_ADDR = 7'h50
) (
	input  logic scl_i,
	input  logic sda_i,   // bus level after the pull-up
	output logic sda_rel_o,
	output int   stop_cnt_o
);
	typedef enum logic [2:0] {m_idle, m_dev, m_addr, m_wr, m_rd} mode_t;

	i2c_byte_t mem [256];
	mode_t     mode      = m_idle;
	i2c_byte_t shreg     = '0;
	i2c_byte_t rd_byte   = '0;
	i2c_byte_t ptr       = '0;
	int        bit_n     = 0;
	logic      slave_ack = 1'b0;  // we hold sda low for the ack bit
	logic      ack_slot  = 1'b0;  // master ack bit after a read byte
	logic      m_ack     = 1'b0;
	logic      scl_prev  = 1'b1;
	logic      sda_prev  = 1'b1;

	initial begin
		for (int a = 0; a < 256; a++)
			mem[a] = 8'((a * 37) + 11);
		sda_rel_o  = 1'b1;
		stop_cnt_o = 0;
	end

	task on_scl_rise();
		if (mode == m_rd) begin
			if (ack_slot)
				m_ack = !sda_i;
			else
				bit_n = bit_n + 1;
		end else if (mode != m_idle && !slave_ack) begin
			shreg = {shreg[6:0], sda_i};
			bit_n = bit_n + 1;
		end
	endtask

	task on_scl_fall();
		if (slave_ack) begin
			slave_ack = 1'b0;
			bit_n     = 0;
			sda_rel_o = (mode == m_rd) ? rd_byte[7] : 1'b1;
		end else if (mode == m_rd) begin
			if (ack_slot) begin
				ack_slot = 1'b0;
				if (m_ack) begin
					ptr       = ptr + 8'd1;  // sequential read
					rd_byte   = mem[ptr];
					bit_n     = 0;
					sda_rel_o = rd_byte[7];
				end else begin
					sda_rel_o = 1'b1;
					mode      = m_idle;
				end
			end else if (bit_n == 8) begin
				sda_rel_o = 1'b1;
				ack_slot  = 1'b1;
			end else begin
				sda_rel_o = rd_byte[3'(7 - bit_n)];
			end
		end else if (mode != m_idle && bit_n == 8) begin
			case (mode)
				m_dev:
					if (shreg[7:1] == DEV_ADDR) begin
						slave_ack = 1'b1;
						rd_byte   = mem[ptr];
						mode      = shreg[0] ? m_rd : m_addr;
					end else begin
						mode = m_idle;  // not ours
					end
				m_addr: begin
					ptr       = shreg;
					mode      = m_wr;
					slave_ack = 1'b1;
				end
				default: begin
					mem[ptr]  = shreg;
					ptr       = ptr + 8'd1;
					slave_ack = 1'b1;
				end
			endcase
			sda_rel_o = !slave_ack;
		end
	endtask

	always @(scl_i or sda_i) begin
		if (scl_i !== scl_prev) begin
			if (scl_i === 1'b1)
				on_scl_rise();
			else if (scl_i === 1'b0)
				on_scl_fall();
		end else if (scl_i === 1'b1 && sda_i !== sda_prev) begin
			if (sda_i === 1'b0) begin
				mode      = m_dev;  // start or repeated start
				bit_n     = 0;
				slave_ack = 1'b0;
				ack_slot  = 1'b0;
				sda_rel_o = 1'b1;
			end else if (sda_i === 1'b1 && sda_prev === 1'b0) begin
				mode       = m_idle;
				stop_cnt_o = stop_cnt_o + 1;
				sda_rel_o  = 1'b1;
			end
		end
		scl_prev = scl_i;
		sda_prev = sda_i;
	end

endmodule

// ==== sim/tb_i2c_master.sv ====
// expects the model at device address 0x50; read data is checked against a shadow copy of its memory
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module tb_i2c_master import i2c_pkg::*; ();
	localparam int NROWS = 9;
	localparam int LIMIT = NROWS * 50 * 2 * `I2C_HALF_CYCLES * 2;
	localparam logic [6:0] DEV_ADDR = 7'h50;

	logic      clk;
	logic      n_rst;
	logic      start;
	i2c_op_t   op;
	logic      page;
	logic [6:0] dev_addr;
	i2c_byte_t word_addr;
	i2c_word_t wdata;
	logic      scl;
	logic      sda_o;
	logic      sda_t;
	i2c_word_t rdata;
	logic      idle;
	logic      model_rel;
	int        stop_cnt;
	wire       sda_bus;

	string     name_tbl  [NROWS] = '{"byte_write", "page_write", "page_read", "single_read",
		"fill_read", "page_write2", "single_read2", "byte_write2", "page_read2"};
	i2c_op_t   op_tbl    [NROWS] = '{op_write, op_write, op_read, op_read, op_read,
		op_write, op_read, op_write, op_read};
	logic      page_tbl  [NROWS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
	i2c_byte_t addr_tbl  [NROWS] = '{8'h10, 8'h20, 8'h20, 8'h10, 8'h80,
		8'h40, 8'h43, 8'h41, 8'h40};
	i2c_word_t wdata_tbl [NROWS];
	i2c_word_t exp_tbl   [NROWS];
	i2c_byte_t shadow    [256];

	integer seed;
	int     errors = 0;
	int     tests_ok = 0;
	int     tests_bad = 0;
	int     cycles = 0;
	int     stop_base = 0;  // reset edges on scl and sda can look like a stop to the model

	assign sda_bus = (sda_t ? 1'b1 : sda_o) & model_rel;  // open drain with pull-up

	i2c_eeprom_master u_i2c_eeprom_master (
		.clk         (clk),
		.n_rst       (n_rst),
		.start_i     (start),
		.op_i        (op),
		.page_i      (page),
		.dev_addr_i  (dev_addr),
		.word_addr_i (word_addr),
		.wdata_i     (wdata),
		.sda_i       (sda_bus),
		.scl_o       (scl),
		.sda_o       (sda_o),
		.sda_t_o     (sda_t),
		.rdata_o     (rdata),
		.idle_o      (idle)
	);

	eeprom_model #(.DEV_ADDR(DEV_ADDR)) u_eeprom_model (
		.scl_i      (scl),
		.sda_i      (sda_bus),
		.sda_rel_o  (model_rel),
		.stop_cnt_o (stop_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles, the DUT did not return to idle", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic i2c_byte_t initial_byte(input int a);
		return 8'((a * 37) + 11);  // same fill the model starts from
	endfunction

	task automatic check_word(input string name, input i2c_word_t exp, input i2c_word_t act);
		if (act !== exp) begin
			$display("mismatch %s rdata expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
		if (act !== exp) begin
			$display("mismatch %s memory byte expected %h actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("mismatch %s stop count expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0) begin
			$display("test %s ok", name);
			tests_ok++;
		end else begin
			$display("test %s failed", name);
			tests_bad++;
		end
	endtask

	// walks the table once so every read row knows the word it must return
	task automatic build_table();
		i2c_word_t rd_prev;
		int        n;
		for (int a = 0; a < 256; a++)
			shadow[a] = initial_byte(a);
		rd_prev = '0;
		for (int r = 0; r < NROWS; r++) begin
			wdata_tbl[r] = $random(seed);
			n = page_tbl[r] ? `I2C_PAGE_BYTES : 1;
			for (int k = 0; k < n; k++) begin
				if (op_tbl[r] == op_write)
					shadow[8'(addr_tbl[r] + 8'(k))] = wdata_tbl[r][8*k +: 8];
				else
					rd_prev[8*k +: 8] = shadow[8'(addr_tbl[r] + 8'(k))];
			end
			exp_tbl[r] = rd_prev;
		end
	endtask

	task automatic run_row(input int r);
		int err0;
		int n;
		err0      = errors;
		op        = op_tbl[r];
		page      = page_tbl[r];
		word_addr = addr_tbl[r];
		wdata     = wdata_tbl[r];
		start     = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_bit({name_tbl[r], " idle after start"}, 1'b0, idle);
		repeat (3) @(negedge clk);
		start = 1'b1;  // busy, must be ignored
		@(negedge clk);
		start = 1'b0;
		while (!idle)
			@(negedge clk);
		check_word(name_tbl[r], exp_tbl[r], rdata);
		n = page_tbl[r] ? `I2C_PAGE_BYTES : 1;
		if (op_tbl[r] == op_write) begin
			for (int k = 0; k < n; k++)
				check_byte(name_tbl[r], wdata_tbl[r][8*k +: 8],
					u_eeprom_model.mem[8'(addr_tbl[r] + 8'(k))]);
		end
		check_count(name_tbl[r], stop_base + r + 1, stop_cnt);
		report_test(name_tbl[r], err0);
	endtask

	initial begin
		n_rst     = 1'b0;
		start     = 1'b0;
		op        = op_write;
		page      = 1'b0;
		dev_addr  = DEV_ADDR;
		word_addr = '0;
		wdata     = '0;
		seed      = 78966;
		build_table();
		repeat (8) @(negedge clk);
		n_rst = 1'b1;
		@(negedge clk);
		check_bit("reset scl", 1'b1, scl);
		check_bit("reset sda_t", 1'b1, sda_t);
		check_bit("reset sda_o", 1'b0, sda_o);
		check_bit("reset idle", 1'b1, idle);
		report_test("reset", 0);
		stop_base = stop_cnt;
		for (int r = 0; r < NROWS; r++)
			run_row(r);
		$display("tests ok %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
verilog/i2c_pkg.sv
verilog/scl_timer.sv
verilog/i2c_bit_shifter.sv
verilog/i2c_data_regs.sv
verilog/i2c_seq_fsm.sv
verilog/i2c_eeprom_master.sv
sim/eeprom_model.sv
sim/tb_i2c_master.sv

// ==== verilog/i2c_bit_shifter.sv ====
// msb first; only pulls sda low or releases it, the bus high level comes from the pull-up
`timescale 1ns/10ps

module i2c_bit_shifter import i2c_pkg::*; (
	input  logic      clk,
	input  logic      n_rst,
	input  logic      load_i,
	input  i2c_byte_t tx_byte_i,
	input  logic      dir_rx_i,
	input  logic      force_low_i,
	input  logic      release_i,
	input  logic      scl_i,
	input  logic      mid_tick_i,
	input  logic      end_tick_i,
	input  logic      sda_i,
	output logic      sda_t_o,
	output i2c_byte_t rx_byte_o,
	output logic      byte_done_o,
	output logic      ack_seen_o
);
	i2c_byte_t  shift_q;  // tx bits leave at the top, rx bits enter at the bottom
	logic [2:0] bit_q;
	logic       sda_t_q;
	logic       ack_q;

	always_ff @(posedge clk) begin
		if (load_i)
			shift_q <= tx_byte_i;
		else if (mid_tick_i && scl_i)
			shift_q <= {shift_q[6:0], sda_i};  // sample at mid-high
	end

	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			sda_t_q <= 1'b1;
			bit_q   <= '0;
			ack_q   <= 1'b0;
		end else begin
			if (force_low_i)
				sda_t_q <= 1'b0;
			else if (release_i)
				sda_t_q <= 1'b1;
			else if (mid_tick_i && !scl_i)
				sda_t_q <= dir_rx_i | shift_q[7];  // stays released while receiving

			// one bit ends at each scl fall
			if (load_i)
				bit_q <= '0;
			else if (end_tick_i && scl_i)
				bit_q <= bit_q + 3'd1;

			if (mid_tick_i && scl_i)
				ack_q <= ~sda_i;  // low on the bus means ack
		end
	end

	assign sda_t_o     = sda_t_q;
	assign rx_byte_o   = shift_q;
	assign byte_done_o = end_tick_i && scl_i && (bit_q == 3'd7);
	assign ack_seen_o  = ack_q;

	// data moves only in the low half, start, stop and repeated start come from the fsm
	assert property (@(posedge clk) disable iff (!n_rst)
		(scl_i && $past(scl_i) && (sda_t_o != $past(sda_t_o)))
		|-> $past(force_low_i || release_i));

endmodule

// ==== verilog/i2c_data_regs.sv ====
// request is frozen at start; read bytes not covered by a read keep their previous value
`timescale 1ns/10ps

module i2c_data_regs import i2c_pkg::*; (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       capture_i,
	input  logic [6:0] dev_addr_i,
	input  i2c_byte_t  word_addr_i,
	input  i2c_op_t    op_i,
	input  i2c_word_t  wdata_i,
	input  i2c_phase_t phase_i,
	input  byte_idx_t  byte_idx_i,
	input  logic       rx_store_i,
	input  i2c_byte_t  rx_byte_i,
	input  logic       idle_i,
	output i2c_byte_t  tx_byte_o,
	output i2c_word_t  rdata_o
);
	logic [6:0] dev_q;
	i2c_byte_t  waddr_q;
	i2c_word_t  wdata_q;
	i2c_op_t    op_q;
	i2c_word_t  asm_q;   // read bytes land here as they arrive
	i2c_word_t  hold_q;  // shown while a transaction runs

	always_ff @(posedge clk) begin
		if (capture_i) begin
			dev_q   <= dev_addr_i;
			waddr_q <= word_addr_i;
			wdata_q <= wdata_i;
		end
	end

	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			op_q   <= op_write;
			asm_q  <= '0;
			hold_q <= '0;
		end else begin
			if (capture_i)
				op_q <= op_i;
			if (rx_store_i && (op_q == op_read))
				asm_q[{byte_idx_i, 3'b000} +: 8] <= rx_byte_i;
			if (idle_i)
				hold_q <= asm_q;
		end
	end

	always_comb begin
		case (phase_i)
			ph_dev_w:     tx_byte_o = {dev_q, 1'b0};
			ph_dev_r:     tx_byte_o = {dev_q, 1'b1};  // second device byte carries the read bit
			ph_word_addr: tx_byte_o = waddr_q;
			default:      tx_byte_o = wdata_q[{byte_idx_i, 3'b000} +: 8];
		endcase
	end

	// new word appears in the same cycle the fsm is back in idle
	assign rdata_o = idle_i ? asm_q : hold_q;

endmodule

// ==== verilog/i2c_eeprom_master.sv ====
// single master, no clock stretching; sda_o is tied low and sda_t_o high releases the line
`timescale 1ns/10ps

module i2c_eeprom_master import i2c_pkg::*; (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       start_i,
	input  i2c_op_t    op_i,
	input  logic       page_i,
	input  logic [6:0] dev_addr_i,
	input  i2c_byte_t  word_addr_i,
	input  i2c_word_t  wdata_i,
	input  logic       sda_i,
	output logic       scl_o,
	output logic       sda_o,
	output logic       sda_t_o,
	output i2c_word_t  rdata_o,
	output logic       idle_o
);
	logic       run;
	logic       mid_tick;
	logic       end_tick;
	logic       load;
	logic       dir_rx;
	logic       force_low;
	logic       sda_release;
	logic       byte_done;
	logic       ack_seen;
	logic       capture;
	logic       rx_store;
	byte_idx_t  byte_idx;
	i2c_phase_t phase;
	i2c_byte_t  tx_byte;
	i2c_byte_t  rx_byte;

	assign sda_o = 1'b0;  // open drain

	i2c_seq_fsm u_seq_fsm (
		.clk         (clk),
		.n_rst       (n_rst),
		.start_i     (start_i),
		.op_i        (op_i),
		.page_i      (page_i),
		.mid_tick_i  (mid_tick),
		.end_tick_i  (end_tick),
		.scl_i       (scl_o),
		.byte_done_i (byte_done),
		.ack_seen_i  (ack_seen),
		.run_o       (run),
		.load_o      (load),
		.dir_rx_o    (dir_rx),
		.force_low_o (force_low),
		.release_o   (sda_release),
		.byte_idx_o  (byte_idx),
		.phase_o     (phase),
		.capture_o   (capture),
		.rx_store_o  (rx_store),
		.idle_o      (idle_o)
	);

	scl_timer u_scl_timer (
		.clk        (clk),
		.n_rst      (n_rst),
		.run_i      (run),
		.scl_o      (scl_o),
		.mid_tick_o (mid_tick),
		.end_tick_o (end_tick)
	);

	i2c_bit_shifter u_bit_shifter (
		.clk         (clk),
		.n_rst       (n_rst),
		.load_i      (load),
		.tx_byte_i   (tx_byte),
		.dir_rx_i    (dir_rx),
		.force_low_i (force_low),
		.release_i   (sda_release),
		.scl_i       (scl_o),
		.mid_tick_i  (mid_tick),
		.end_tick_i  (end_tick),
		.sda_i       (sda_i),
		.sda_t_o     (sda_t_o),
		.rx_byte_o   (rx_byte),
		.byte_done_o (byte_done),
		.ack_seen_o  (ack_seen)
	);

	i2c_data_regs u_data_regs (
		.clk         (clk),
		.n_rst       (n_rst),
		.capture_i   (capture),
		.dev_addr_i  (dev_addr_i),
		.word_addr_i (word_addr_i),
		.op_i        (op_i),
		.wdata_i     (wdata_i),
		.phase_i     (phase),
		.byte_idx_i  (byte_idx),
		.rx_store_i  (rx_store),
		.rx_byte_i   (rx_byte),
		.idle_i      (idle_o),
		.tx_byte_o   (tx_byte),
		.rdata_o     (rdata_o)
	);

endmodule

// ==== verilog/i2c_pkg.sv ====
// shared bus types; byte and word widths are fixed, the phase enum must stay within 4 bits
package i2c_pkg;

	typedef enum logic {
		op_write = 1'b0,
		op_read  = 1'b1
	} i2c_op_t;

	typedef logic [7:0]  i2c_byte_t;
	typedef logic [31:0] i2c_word_t;  // byte k sits in bits 8k+7 down to 8k
	typedef logic [1:0]  byte_idx_t;

	typedef enum logic [3:0] {
		ph_idle,
		ph_start,
		ph_dev_w,
		ph_word_addr,
		ph_wr_data,
		ph_rd_data,
		ph_ack_in,
		ph_ack_out,
		ph_rstart,
		ph_dev_r,
		ph_stop
	} i2c_phase_t;

endpackage

// ==== verilog/i2c_seq_fsm.sv ====
// waits forever for a slave acknowledge; a start pulse is taken only in idle, never queued
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_seq_fsm import i2c_pkg::*; (
	input  logic       clk,
	input  logic       n_rst,
	input  logic       start_i,
	input  i2c_op_t    op_i,
	input  logic       page_i,
	input  logic       mid_tick_i,
	input  logic       end_tick_i,
	input  logic       scl_i,
	input  logic       byte_done_i,
	input  logic       ack_seen_i,
	output logic       run_o,
	output logic       load_o,
	output logic       dir_rx_o,
	output logic       force_low_o,
	output logic       release_o,
	output byte_idx_t  byte_idx_o,
	output i2c_phase_t phase_o,
	output logic       capture_o,
	output logic       rx_store_o,
	output logic       idle_o
);
	i2c_phase_t state_q;
	i2c_phase_t state_d;
	i2c_phase_t prev_q;  // last byte phase, decides where an ack leads
	byte_idx_t  cnt_q;
	logic       cnt_inc;
	i2c_op_t    op_q;
	logic       page_q;
	logic       load_q;
	logic       stop_q;  // sda went high during the stop bit
	logic       low_mid;
	logic       high_mid;
	logic       scl_fall;
	logic       last_byte;
	logic       accept;

	assign low_mid   = mid_tick_i & ~scl_i;
	assign high_mid  = mid_tick_i & scl_i;
	assign scl_fall  = end_tick_i & scl_i;
	assign accept    = (state_q == ph_idle) & start_i;
	assign last_byte = ~page_q | (cnt_q == byte_idx_t'(`I2C_PAGE_BYTES - 1));

	always_comb begin
		state_d = state_q;
		cnt_inc = 1'b0;
		case (state_q)
			ph_idle:
				if (start_i)
					state_d = ph_start;
			ph_start:
				if (scl_fall)
					state_d = ph_dev_w;  // start hold time is one half period
			ph_dev_w, ph_word_addr, ph_wr_data, ph_dev_r:
				if (byte_done_i)
					state_d = ph_ack_in;
			ph_ack_in:
				if (scl_fall && ack_seen_i) begin
					case (prev_q)
						ph_dev_w:     state_d = ph_word_addr;
						ph_word_addr: state_d = (op_q == op_read) ? ph_rstart : ph_wr_data;
						ph_dev_r:     state_d = ph_rd_data;
						ph_wr_data: begin
							state_d = last_byte ? ph_stop : ph_wr_data;
							cnt_inc = ~last_byte;
						end
						default:      state_d = ph_stop;
					endcase
				end
			ph_rd_data:
				if (byte_done_i)
					state_d = ph_ack_out;
			ph_ack_out:
				if (scl_fall) begin
					state_d = last_byte ? ph_stop : ph_rd_data;
					cnt_inc = ~last_byte;
				end
			ph_rstart:
				if (scl_fall)
					state_d = ph_dev_r;
			ph_stop:
				if (stop_q)
					state_d = ph_idle;
			default: state_d = ph_idle;
		endcase
	end

	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			state_q <= ph_idle;
			prev_q  <= ph_idle;
			cnt_q   <= '0;
			op_q    <= op_write;
			page_q  <= 1'b0;
			load_q  <= 1'b0;
			stop_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q != ph_ack_in)
				prev_q <= state_q;
			if (accept) begin
				op_q   <= op_i;
				page_q <= page_i;
				cnt_q  <= '0;
			end else if (cnt_inc) begin
				cnt_q <= cnt_q + 2'd1;
			end
			// byte phases are always entered from a different phase
			load_q <= (state_d != state_q) &&
				(state_d inside {ph_dev_w, ph_word_addr, ph_wr_data, ph_dev_r, ph_rd_data});
			stop_q <= (state_q == ph_stop) && high_mid;
		end
	end

	assign run_o       = (state_q != ph_idle);
	assign load_o      = load_q;
	assign dir_rx_o    = (state_q == ph_rd_data) || (state_q == ph_ack_in);
	assign force_low_o = accept                             // start condition
		|| ((state_q == ph_ack_out) && low_mid && !last_byte)  // master ack
		|| ((state_q == ph_rstart) && high_mid)
		|| ((state_q == ph_stop) && low_mid);
	assign release_o   = ((state_q == ph_ack_out) && low_mid && last_byte)  // nack
		|| ((state_q == ph_rstart) && low_mid)
		|| ((state_q == ph_stop) && high_mid);
	assign byte_idx_o  = cnt_q;
	assign phase_o     = state_q;
	assign capture_o   = accept;
	assign rx_store_o  = (state_q == ph_rd_data) && byte_done_i;
	assign idle_o      = (state_q == ph_idle);

	// loads come one cycle into a byte phase and stores on its last cycle
	assert property (@(posedge clk) disable iff (!n_rst) !(load_o && rx_store_o));

endmodule

// ==== verilog/scl_timer.sv ====
// scl is driven by the master only with no clock stretching; half period must fit the counter
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module scl_timer (
	input  logic clk,
	input  logic n_rst,
	input  logic run_i,
	output logic scl_o,
	output logic mid_tick_o,
	output logic end_tick_o
);
	typedef logic [`I2C_CNT_W-1:0] cnt_t;

	localparam cnt_t MID_CNT  = cnt_t'(`I2C_HALF_CYCLES / 2 - 1);
	localparam cnt_t LAST_CNT = cnt_t'(`I2C_HALF_CYCLES - 1);

	cnt_t cnt_q;
	logic scl_q;

	assign mid_tick_o = run_i && (cnt_q == MID_CNT);
	assign end_tick_o = run_i && (cnt_q == LAST_CNT);
	assign scl_o      = scl_q;

	always_ff @(posedge clk or negedge n_rst) begin
		if (!n_rst) begin
			cnt_q <= '0;
			scl_q <= 1'b1;  // bus idle level
		end else if (!run_i) begin
			cnt_q <= '0;
			scl_q <= 1'b1;
		end else if (end_tick_o) begin
			cnt_q <= '0;
			scl_q <= ~scl_q;
		end else begin
			cnt_q <= cnt_q + cnt_t'(1);
		end
	end

	// the fsm only stops the timer during a high half, so scl moves only on a tick
	assert property (@(posedge clk) disable iff (!n_rst) $changed(scl_o) |-> $past(end_tick_o));

endmodule
